// File: Makefile
# Verilator build and run for the PS/2 key display

VERILATOR ?= verilator
TOP       ?= ps2_key_display_tb
RTL_TOP   ?= ps2_key_display
FILELIST  ?= ps2_key_display.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only -Wall --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation FAILED" $(LOG); then \
		echo "Run failed, see $(LOG)"; exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/key_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module key_decoder
    import ps2_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [code_width-1:0] code,
    input  logic                  code_ready,
    output logic                  code_pop,
    output logic [code_width-1:0] key_code
);

    key_state_t state;
    key_state_t state_next;
    logic       break_seen;

    always_ff @(posedge clk)
    begin
        if (!rst)
            state <= key_idle;
        else
            state <= state_next;
    end

    always_comb
    begin
        state_next = state;
        case (state)
            key_idle:
            begin
                if (code_ready)
                    state_next = key_fetch;
            end
            key_fetch:
            begin
                if (code == break_code)
                    state_next = key_break;
                else
                    state_next = key_make;
            end
            key_make:
            begin
                state_next = key_idle;
            end
            key_break:
            begin
                state_next = key_idle;
            end
            default:
            begin
                state_next = key_idle;
            end
        endcase
    end

    // One pop per fetch, head of FIFO is consumed on this edge
    assign code_pop = (state == key_fetch);

    // Set by F0, cleared by any other code
    always_ff @(posedge clk)
    begin
        if (!rst)
            break_seen <= 1'b0;
        else if (state == key_break)
            break_seen <= 1'b1;
        else if (state == key_make)
            break_seen <= 1'b0;
    end

    // Only released keys reach the display, typematic repeats are ignored
    always_ff @(posedge clk)
    begin
        if (!rst)
            key_code <= '0;
        else if (state == key_fetch && break_seen)
            key_code <= code;
    end

endmodule

`default_nettype wire

// File: design/ps2_key_display.sv
`default_nettype none
`timescale 1ns/10ps

module ps2_key_display
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       ps2_clk,
    input  logic       ps2_dat,
    output logic [7:0] seg_lo,
    output logic [7:0] seg_hi
);

    logic [code_width-1:0] code;
    logic                  code_ready;
    logic                  code_pop;
    logic [code_width-1:0] key_code;

    ps2_rx ps2_rx_i (
        .clk        (clk),
        .rst        (rst),
        .ps2_clk    (ps2_clk),
        .ps2_dat    (ps2_dat),
        .code_pop   (code_pop),
        .code       (code),
        .code_ready (code_ready)
    );

    key_decoder key_decoder_i (
        .clk        (clk),
        .rst        (rst),
        .code       (code),
        .code_ready (code_ready),
        .code_pop   (code_pop),
        .key_code   (key_code)
    );

    // Low nibble on the right-hand digit
    seg7_decoder seg_lo_dec (
        .clk        (clk),
        .rst        (rst),
        .nibble     (key_code[3:0]),
        .seg        (seg_lo)
    );

    seg7_decoder seg_hi_dec (
        .clk        (clk),
        .rst        (rst),
        .nibble     (key_code[7:4]),
        .seg        (seg_hi)
    );

endmodule

`default_nettype wire

// File: design/ps2_pkg.sv
`default_nettype none

package ps2_pkg;

    // Scan code format
    localparam int code_width = 8;
    localparam logic [code_width-1:0] break_code = 8'hF0;

    // Scan code FIFO
    localparam int fifo_depth = 8;
    localparam int fifo_addr_width = 3;

    // Watchdog for a stalled frame, in system clocks
    localparam int frame_timeout = 1023;
    localparam int timeout_width = 10;

    // Flops between the PS/2 pins and the core logic
    localparam int sync_stages = 2;

    // Frame is start, 8 data, parity, stop
    localparam int frame_bits = 11;
    localparam int bit_cnt_width = 4;

    // Break-code decoder states
    typedef enum logic [1:0] {
        key_idle,
        key_fetch,
        key_make,
        key_break
    } key_state_t;

endpackage

`default_nettype wire

// File: design/ps2_rx.sv
`default_nettype none
`timescale 1ns/10ps

module ps2_rx
    import ps2_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  ps2_clk,
    input  logic                  ps2_dat,
    input  logic                  code_pop,
    output logic [code_width-1:0] code,
    output logic                  code_ready
);

    logic [sync_stages-1:0]      clk_sync;
    logic [sync_stages-1:0]      dat_sync;
    logic                        clk_prev;
    logic                        clk_fall;

    logic [bit_cnt_width-1:0]    bit_cnt;
    logic [frame_bits-2:0]       shift;
    logic [timeout_width-1:0]    idle_cnt;
    logic                        frame_good;
    logic                        stop_bit;
    logic                        timed_out;

    logic [code_width-1:0]       mem [fifo_depth];
    logic [fifo_addr_width-1:0]  wr_ptr;
    logic [fifo_addr_width-1:0]  rd_ptr;
    logic [fifo_addr_width:0]    fill;
    logic                        fifo_full;
    logic                        push;
    logic                        pop;

    // Both lines idle high, so the synchronizers reset to ones
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_sync <= '1;
            dat_sync <= '1;
        end
        else
        begin
            clk_sync <= {clk_sync[sync_stages-2:0], ps2_clk};
            dat_sync <= {dat_sync[sync_stages-2:0], ps2_dat};
        end
    end

    // Registered falling-edge strobe of the synchronized PS/2 clock
    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            clk_prev <= 1'b1;
            clk_fall <= 1'b0;
        end
        else
        begin
            clk_prev <= clk_sync[sync_stages-1];
            clk_fall <= clk_prev & ~clk_sync[sync_stages-1];
        end
    end

    assign stop_bit  = dat_sync[sync_stages-1];
    assign timed_out = (idle_cnt == timeout_width'(frame_timeout));

    // shift[0] is the start bit, shift[8:1] the data, shift[9] the parity
    assign frame_good = clk_fall
                        && (bit_cnt == bit_cnt_width'(frame_bits - 1))
                        && !shift[0]
                        && (^shift[frame_bits-2:1])
                        && stop_bit;

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            bit_cnt <= '0;
        end
        else if (clk_fall)
        begin
            if (bit_cnt == bit_cnt_width'(frame_bits - 1))
                bit_cnt <= '0;
            else
                bit_cnt <= bit_cnt + 1'b1;
        end
        else if (timed_out)
        begin
            // Stalled frame, wait for a new start bit
            bit_cnt <= '0;
        end
    end

    // Payload shift register, LSB first
    always_ff @(posedge clk)
    begin
        if (clk_fall && bit_cnt != bit_cnt_width'(frame_bits - 1))
            shift <= {dat_sync[sync_stages-1], shift[frame_bits-2:1]};
    end

    // Watchdog runs only inside a partial frame
    always_ff @(posedge clk)
    begin
        if (!rst)
            idle_cnt <= '0;
        else if (clk_fall || bit_cnt == '0 || timed_out)
            idle_cnt <= '0;
        else
            idle_cnt <= idle_cnt + 1'b1;
    end

    // Scan code FIFO
    assign fifo_full  = (fill == (fifo_addr_width + 1)'(fifo_depth));
    assign push       = frame_good && !fifo_full;
    assign pop        = code_pop && code_ready;
    assign code_ready = (fill != '0);
    assign code       = mem[rd_ptr];

    always_ff @(posedge clk)
    begin
        if (push)
            mem[wr_ptr] <= shift[code_width:1];
    end

    always_ff @(posedge clk)
    begin
        if (!rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (push)
                wr_ptr <= wr_ptr + 1'b1;
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/seg7_decoder.sv
`default_nettype none
`timescale 1ns/10ps

module seg7_decoder
    import ps2_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic [3:0] nibble,
    output logic [7:0] seg
);

    // Active low, bit order dp g f e d c b a
    always_ff @(posedge clk)
    begin
        if (!rst)
            seg <= 8'hC0;
        else
        begin
            case (nibble)
                4'h0: seg <= 8'hC0;
                4'h1: seg <= 8'hF9;
                4'h2: seg <= 8'hA4;
                4'h3: seg <= 8'hB0;
                4'h4: seg <= 8'h99;
                4'h5: seg <= 8'h92;
                4'h6: seg <= 8'h82;
                4'h7: seg <= 8'hF8;
                4'h8: seg <= 8'h80;
                4'h9: seg <= 8'h90;
                4'hA: seg <= 8'h88;
                4'hB: seg <= 8'h83;  // lower-case b
                4'hC: seg <= 8'hC6;
                4'hD: seg <= 8'hA1;  // lower-case d
                4'hE: seg <= 8'h86;
                default: seg <= 8'h8E;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: dv/ps2_key_display_tb.sv
`default_nettype none
`timescale 1ns/10ps

module ps2_key_display_tb
    import ps2_pkg::*;
();

    logic       clk;
    logic       rst;
    logic       ps2_clk;
    logic       ps2_dat;
    logic [7:0] seg_lo;
    logic [7:0] seg_hi;

    logic [31:0] lfsr_state;
    logic [7:0]  shown_key;
    int          errors;
    int          dp_errors;
    int          tests_passed;
    int          tests_failed;

    ps2_key_display ps2_key_display_i (
        .clk     (clk),
        .rst     (rst),
        .ps2_clk (ps2_clk),
        .ps2_dat (ps2_dat),
        .seg_lo  (seg_lo),
        .seg_hi  (seg_hi)
    );

    always #20 clk = ~clk;

    // Decimal point stays dark on both digits
    assert property (@(posedge clk) disable iff (!rst) seg_lo[7] && seg_hi[7])
    else
    begin
        $display("[ERROR] seg_lo/seg_hi dp: got 0x%02h/0x%02h", seg_lo, seg_hi);
        dp_errors++;
    end

    // Active-low font in dp g f e d c b a order
    function automatic logic [7:0] hex_font(input logic [3:0] n);
        logic [7:0] table_val [16];
        table_val = '{8'hC0, 8'hF9, 8'hA4, 8'hB0, 8'h99, 8'h92, 8'h82, 8'hF8,
                      8'h80, 8'h90, 8'h88, 8'h83, 8'hC6, 8'hA1, 8'h86, 8'h8E};
        return table_val[n];
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
    function automatic logic [7:0] random_code();
        logic [7:0] c;
        int i;
        c = break_code;
        while (c == break_code)
        begin
            for (i = 0; i < 8; i++)
            begin
                c = {c[6:0], lfsr_state[31]};
                lfsr_state = {lfsr_state[30:0],
                              lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0]};
            end
        end
        return c;
    endfunction

    // nbits below 11 leaves a partial frame on the lines
    task automatic send_frame(input logic [7:0] data, input bit bad_parity, input int nbits);
        logic [10:0] frame;
        int i;
        frame = {1'b1, (~^data) ^ bad_parity, data, 1'b0};
        for (i = 0; i < nbits; i++)
        begin
            @(negedge clk);
            ps2_dat = frame[i];
            repeat (8) @(negedge clk);
            ps2_clk = 1'b0;
            repeat (8) @(negedge clk);
            ps2_clk = 1'b1;
        end
        @(negedge clk);
        ps2_dat = 1'b1;
    endtask

    task automatic release_key(input logic [7:0] key);
        send_frame(key, 1'b0, 11);
        send_frame(break_code, 1'b0, 11);
        send_frame(key, 1'b0, 11);
    endtask

    task automatic check_display(input logic [7:0] key, output bit ok);
        ok = 1'b1;
        assert (seg_lo == hex_font(key[3:0]))
        else
        begin
            $display("[ERROR] seg_lo: expected 0x%02h, got 0x%02h", hex_font(key[3:0]), seg_lo);
            errors++;
            ok = 1'b0;
        end
        assert (seg_hi == hex_font(key[7:4]))
        else
        begin
            $display("[ERROR] seg_hi: expected 0x%02h, got 0x%02h", hex_font(key[7:4]), seg_hi);
            errors++;
            ok = 1'b0;
        end
    endtask

    task automatic expect_key(input logic [7:0] key);
        int waited;
        bit ok;
        waited = 0;
        while (!(seg_lo == hex_font(key[3:0]) && seg_hi == hex_font(key[7:4])))
        begin
            if (waited == 200)
            begin
                $display("Timeout: display did not show key %02h within 200 cycles", key);
                errors++;
                break;
            end
            @(negedge clk);
            waited++;
        end
        check_display(key, ok);
        shown_key = key;
    endtask

    // Display must stay on the same key for the whole window
    task automatic hold_key(input logic [7:0] key, input int cycles);
        int n;
        bit ok;
        for (n = 0; n < cycles; n++)
        begin
            @(negedge clk);
            check_display(key, ok);
            if (!ok)
                break;
        end
    endtask

    task automatic report_test(input int num, input string name, input int errors_before);
        if (errors + dp_errors == errors_before)
        begin
            tests_passed++;
            $display("Test %0d %s: pass", num, name);
        end
        else
        begin
            tests_failed++;
            $display("Test %0d %s: fail", num, name);
        end
    endtask

    initial
    begin
        logic [7:0] key;
        int snap;
        int k;
        clk          = 1'b0;
        rst          = 1'b0;
        ps2_clk      = 1'b1;
        ps2_dat      = 1'b1;
        lfsr_state   = 32'h38f7e045;
        shown_key    = 8'h00;
        errors       = 0;
        dp_errors    = 0;
        tests_passed = 0;
        tests_failed = 0;

        repeat (16) @(negedge clk);
        rst = 1'b1;

        snap = errors + dp_errors;
        @(negedge clk);
        hold_key(8'h00, 1);
        report_test(1, "reset display", snap);

        snap = errors + dp_errors;
        release_key(8'h1C);
        expect_key(8'h1C);
        for (k = 0; k < 4; k++)
        begin
            key = random_code();
            release_key(key);
            expect_key(key);
        end
        report_test(2, "released keys", snap);

        // Typematic repeat without a release
        snap = errors + dp_errors;
        for (k = 0; k < 3; k++)
            send_frame(8'h3A, 1'b0, 11);
        hold_key(shown_key, 200);
        report_test(3, "make codes only", snap);

        snap = errors + dp_errors;
        send_frame(break_code, 1'b1, 11);
        send_frame(8'h22, 1'b0, 11);
        hold_key(shown_key, 200);
        send_frame(break_code, 1'b0, 11);
        send_frame(8'h22, 1'b0, 11);
        expect_key(8'h22);
        report_test(4, "bad parity dropped", snap);

        // Idle gap well past the watchdog limit
        snap = errors + dp_errors;
        send_frame(8'h5A, 1'b0, 5);
        repeat (frame_timeout + 100) @(negedge clk);
        send_frame(break_code, 1'b0, 11);
        send_frame(8'h4B, 1'b0, 11);
        expect_key(8'h4B);
        report_test(5, "watchdog resync", snap);

        snap = errors + dp_errors;
        send_frame(8'hE0, 1'b0, 11);
        send_frame(break_code, 1'b0, 11);
        send_frame(8'h75, 1'b0, 11);
        expect_key(8'h75);
        report_test(6, "back-to-back frames", snap);

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (tests_failed == 0 && errors == 0 && dp_errors == 0)
            $display("Simulation PASSED");
        else
            $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: ps2_key_display.f
design/ps2_pkg.sv
design/seg7_decoder.sv
design/ps2_rx.sv
design/key_decoder.sv
design/ps2_key_display.sv
dv/ps2_key_display_tb.sv
